/* all.f */
+incdir+verilog
verilog/mipsPkg.sv
verilog/fetchStage.sv
verilog/decodeStage.sv
verilog/forwardUnit.sv
verilog/executeStage.sv
verilog/memoryStage.sv
verilog/mipsCore.sv
tests/tbClock.sv
tests/mipsCoreTb.sv

/* Makefile */
TOP := mipsCoreTb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert --timescale 1ns/100ps -f all.f --top-module $(TOP) -o simv
	./obj_dir/simv

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/100ps -f all.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* tests/mipsCoreTb.sv */
// program builder, reference model, stimulus and write-back checks for the MIPS core
`timescale 1ns/100ps
`include "mips_settings.svh"

module mipsCoreTb;

	localparam int imemAw = $clog2(`MIPS_IMEM_DEPTH);
	localparam int resetCycles = 16;
	localparam int driveDelayNs = 10;
	localparam int releaseTimeout = 200;
	localparam int wbTimeout = 16;
	localparam int quietCycles = 8;

	logic               clk;
	logic               reset;
	logic               progWrite;
	logic [imemAw-1:0]  progAddr;
	mipsPkg::instrT     progData;
	logic               wbValid;
	mipsPkg::regAddrT   wbReg;
	mipsPkg::wordT      wbData;

	// program image, zero words past progLen act as r0 no-ops
	mipsPkg::instrT     prog [`MIPS_IMEM_DEPTH];
	int                 progLen;
	int                 seed = 32'hf078_f082;

	// expected write-back stream in program order
	mipsPkg::regAddrT   expReg [$];
	mipsPkg::wordT      expVal [$];

	tbClock clockGen (
		.clk(clk)
	);

	mipsCore u_mipsCore (
		.clk(clk),
		.reset(reset),
		.progWrite(progWrite),
		.progAddr(progAddr),
		.progData(progData),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData)
	);

	task automatic stopRun();
		$display("Test FAILED");
		$fatal(1, "simulation stopped on a failed check");
	endtask

	task automatic failWith(input string why);
		$display("%s (time %0t)", why, $time);
		stopRun();
	endtask

	task automatic checkReg(
		input string            name,
		input mipsPkg::regAddrT got,
		input mipsPkg::regAddrT expected
	);
		if (got !== expected) begin
			$display("ERR time=%0t %s got=%0d expected=%0d", $time, name, got, expected);
			stopRun();
		end
	endtask

	task automatic checkWord(
		input string         name,
		input mipsPkg::wordT got,
		input mipsPkg::wordT expected
	);
		if (got !== expected) begin
			$display("ERR time=%0t %s got=%h expected=%h", $time, name, got, expected);
			stopRun();
		end
	endtask

	// uniform value in 0 .. n-1 from the seeded generator
	function automatic int randBelow(input int n);
		logic [31:0] r;
		r = $random(seed);
		return int'(r[30:0]) % n;
	endfunction

	function automatic mipsPkg::instrT encR(input logic [5:0] fn, input int rd, input int rs,
		input int rt);
		return {`MIPS_OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
	endfunction

	function automatic mipsPkg::instrT encI(input logic [5:0] op, input int rt, input int rs,
		input int imm);
		return {op, rs[4:0], rt[4:0], imm[15:0]};
	endfunction

	task automatic emit(input mipsPkg::instrT w);
		prog[progLen] = w;
		progLen++;
	endtask

	task automatic buildProgram();
		logic [5:0] fns [5];
		int slot0;
		int slot1;
		int slot2;
		fns = '{`MIPS_FN_ADD, `MIPS_FN_SUB, `MIPS_FN_AND, `MIPS_FN_OR, `MIPS_FN_SLT};
		progLen = 0;
		for (int k = 0; k < `MIPS_IMEM_DEPTH; k++) begin
			prog[k] = '0;
		end
		// r1..r8 from random immediates, negative ones included
		for (int r = 1; r <= 8; r++) begin
			emit(encI(`MIPS_OP_ADDI, r, 0, randBelow(65536)));
		end
		// every function twice on random sources, close enough to forward
		for (int k = 0; k < 10; k++) begin
			emit(encR(fns[k % 5], 9 + randBelow(4), 1 + randBelow(12), 1 + randBelow(12)));
		end
		// one slot per range so the three store addresses never collide
		slot0 = randBelow(16);
		slot1 = 16 + randBelow(16);
		slot2 = 32 + randBelow(16);
		// dependent chain at distance one and two, store data forwarded
		emit(encI(`MIPS_OP_ADDI, 16, 1, randBelow(65536)));
		emit(encR(`MIPS_FN_ADD, 17, 16, 16));
		emit(encR(`MIPS_FN_SUB, 18, 17, 16));
		emit(encR(`MIPS_FN_OR, 19, 18, 17));
		emit(encI(`MIPS_OP_SW, 19, 0, slot0 * 4));
		emit(encI(`MIPS_OP_SW, 2, 0, slot1 * 4));
		emit(encI(`MIPS_OP_SW, 16, 0, slot2 * 4));
		emit(encI(`MIPS_OP_ADDI, 20, 0, 7));
		// loads back, the top word is never stored to
		emit(encI(`MIPS_OP_LW, 21, 0, slot0 * 4));
		emit(encI(`MIPS_OP_LW, 22, 0, slot1 * 4));
		emit(encI(`MIPS_OP_LW, 23, 0, slot2 * 4));
		emit(encI(`MIPS_OP_LW, 24, 0, (`MIPS_DMEM_DEPTH - 1) * 4));
		emit(encI(`MIPS_OP_ADDI, 25, 0, randBelow(65536)));
		emit(encR(`MIPS_FN_ADD, 26, 21, 22));
		emit(encR(`MIPS_FN_SUB, 27, 23, 24));
		// load then one independent op then the use
		emit(encI(`MIPS_OP_LW, 28, 0, slot1 * 4));
		emit(encI(`MIPS_OP_ADDI, 29, 0, randBelow(65536)));
		emit(encR(`MIPS_FN_AND, 30, 28, 29));
		// writes to r0 are dropped and r0 still reads zero
		emit(encI(`MIPS_OP_ADDI, 0, 3, randBelow(65536)));
		emit(encR(`MIPS_FN_ADD, 0, 1, 2));
		emit(encR(`MIPS_FN_OR, 31, 0, 4));
		emit(encR(`MIPS_FN_SLT, 15, 0, 5));
	endtask

	// runs the program in order and lists every register write but r0
	function automatic void runReference();
		mipsPkg::wordT    regs [1 << `MIPS_REG_ADDR_W];
		mipsPkg::wordT    mem [`MIPS_DMEM_DEPTH];
		mipsPkg::instrT   w;
		mipsPkg::wordT    a;
		mipsPkg::wordT    b;
		mipsPkg::wordT    imm;
		mipsPkg::wordT    res;
		mipsPkg::wordT    addr;
		mipsPkg::regAddrT dst;
		logic             writes;
		int               memIdx;
		for (int i = 0; i < (1 << `MIPS_REG_ADDR_W); i++) begin
			regs[i] = '0;
		end
		for (int i = 0; i < `MIPS_DMEM_DEPTH; i++) begin
			mem[i] = '0;
		end
		for (int k = 0; k < progLen; k++) begin
			w = prog[k];
			a = regs[w[25:21]];
			b = regs[w[20:16]];
			imm = {{16{w[15]}}, w[15:0]};
			addr = a + imm;
			memIdx = int'(addr / 4) % `MIPS_DMEM_DEPTH;
			res = '0;
			dst = w[20:16];
			writes = 1'b1;
			case (w[31:26])
				`MIPS_OP_RTYPE: begin
					dst = w[15:11];
					case (w[5:0])
						`MIPS_FN_SUB: res = a - b;
						`MIPS_FN_AND: res = a & b;
						`MIPS_FN_OR: res = a | b;
						`MIPS_FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: res = a + b;
					endcase
				end
				`MIPS_OP_ADDI: res = addr;
				`MIPS_OP_LW: res = mem[memIdx];
				`MIPS_OP_SW: begin
					mem[memIdx] = b;
					writes = 1'b0;
				end
				default: writes = 1'b0;
			endcase
			if (writes && (dst != '0)) begin
				regs[dst] = res;
				expReg.push_back(dst);
				expVal.push_back(res);
			end
		end
	endfunction

	// load runs under reset, then reset stays high for 16 more cycles
	initial begin : stimulus
		reset = 1'b1;
		progWrite = 1'b0;
		progAddr = '0;
		progData = '0;
		buildProgram();
		runReference();
		for (int k = 0; k < `MIPS_IMEM_DEPTH; k++) begin
			@(posedge clk);
			#driveDelayNs;
			progWrite = 1'b1;
			progAddr = imemAw'(k);
			progData = prog[k];
		end
		@(posedge clk);
		#driveDelayNs;
		progWrite = 1'b0;
		repeat (resetCycles) @(posedge clk);
		#driveDelayNs;
		reset = 1'b0;
	end

	// nothing may come out of write-back while reset is high
	always @(negedge clk) begin
		if ((reset === 1'b1) && (wbValid !== 1'b0)) begin
			failWith("write-back valid while reset is high");
		end
	end

	// outputs are sampled on the falling edge, halfway between drive points
	initial begin : compare
		int waitCount;
		waitCount = 0;
		while (reset !== 1'b0) begin
			@(negedge clk);
			waitCount++;
			if (waitCount > releaseTimeout) begin
				failWith("reset was never released");
			end
		end
		for (int idx = 0; idx < expReg.size(); idx++) begin
			waitCount = 0;
			@(negedge clk);
			while (wbValid !== 1'b1) begin
				waitCount++;
				if (waitCount > wbTimeout) begin
					failWith($sformatf("timed out waiting for write-back %0d", idx));
				end
				@(negedge clk);
			end
			checkReg("wbReg", wbReg, expReg[idx]);
			checkWord("wbData", wbData, expVal[idx]);
		end
		// list used up, the padding words must stay silent
		for (int c = 0; c < quietCycles; c++) begin
			@(negedge clk);
			if (wbValid !== 1'b0) begin
				failWith("write-back seen after the last expected entry");
			end
		end
		$display("Test OK");
		$finish;
	end

endmodule

/* tests/tbClock.sv */
// free-running testbench clock, 100 ns period
`timescale 1ns/100ps

module tbClock #(
	parameter int periodNs = 100
) (
	output logic clk
);

	// low for the first half period, then toggles forever
	initial begin
		clk = 1'b0;
		forever begin
			#(periodNs / 2) clk = ~clk;
		end
	end

endmodule

/* verilog/mipsCore.sv */
// five-stage MIPS pipeline top, stage instances and their wiring
`timescale 1ns/100ps
`include "mips_settings.svh"

module mipsCore (
	input  logic                                clk,
	input  logic                                reset,
	input  logic                                progWrite,
	input  logic [$clog2(`MIPS_IMEM_DEPTH)-1:0] progAddr,
	input  mipsPkg::instrT                      progData,
	output logic                                wbValid,
	output mipsPkg::regAddrT                    wbReg,
	output mipsPkg::wordT                       wbData
);

	// fetch/decode
	mipsPkg::instrT   ifidInstr;

	// decode/execute
	mipsPkg::ctrlT    idexCtrl;
	mipsPkg::regAddrT idexRs;
	mipsPkg::regAddrT idexRt;
	mipsPkg::regAddrT idexRd;
	mipsPkg::wordT    idexA;
	mipsPkg::wordT    idexB;
	mipsPkg::wordT    idexImm;

	// execute/memory
	mipsPkg::ctrlT    exmemCtrl;
	mipsPkg::wordT    exmemAlu;
	mipsPkg::wordT    exmemStore;
	mipsPkg::regAddrT exmemDst;

	// operand source selects
	logic [1:0]       fwdA;
	logic [1:0]       fwdB;

	fetchStage u_fetchStage (
		.clk(clk),
		.reset(reset),
		.progWrite(progWrite),
		.progAddr(progAddr),
		.progData(progData),
		.ifidInstr(ifidInstr)
	);

	// write-back stream doubles as the register-file write port
	decodeStage u_decodeStage (
		.clk(clk),
		.reset(reset),
		.ifidInstr(ifidInstr),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData),
		.idexCtrl(idexCtrl),
		.idexRs(idexRs),
		.idexRt(idexRt),
		.idexRd(idexRd),
		.idexA(idexA),
		.idexB(idexB),
		.idexImm(idexImm)
	);

	forwardUnit u_forwardUnit (
		.idexRs(idexRs),
		.idexRt(idexRt),
		.exmemCtrl(exmemCtrl),
		.exmemDst(exmemDst),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.fwdA(fwdA),
		.fwdB(fwdB)
	);

	executeStage u_executeStage (
		.clk(clk),
		.reset(reset),
		.idexCtrl(idexCtrl),
		.idexRt(idexRt),
		.idexRd(idexRd),
		.idexA(idexA),
		.idexB(idexB),
		.idexImm(idexImm),
		.fwdA(fwdA),
		.fwdB(fwdB),
		.wbData(wbData),
		.exmemCtrl(exmemCtrl),
		.exmemAlu(exmemAlu),
		.exmemStore(exmemStore),
		.exmemDst(exmemDst)
	);

	memoryStage u_memoryStage (
		.clk(clk),
		.reset(reset),
		.exmemCtrl(exmemCtrl),
		.exmemAlu(exmemAlu),
		.exmemStore(exmemStore),
		.exmemDst(exmemDst),
		.wbValid(wbValid),
		.wbReg(wbReg),
		.wbData(wbData)
	);

endmodule

/* verilog/memoryStage.sv */
// data memory, memory/write-back register and write-back mux
`timescale 1ns/100ps
`include "mips_settings.svh"

module memoryStage (
	input  logic             clk,
	input  logic             reset,
	input  mipsPkg::ctrlT    exmemCtrl,
	input  mipsPkg::wordT    exmemAlu,
	input  mipsPkg::wordT    exmemStore,
	input  mipsPkg::regAddrT exmemDst,
	output logic             wbValid,
	output mipsPkg::regAddrT wbReg,
	output mipsPkg::wordT    wbData
);

	localparam int dmemAw = $clog2(`MIPS_DMEM_DEPTH);

	mipsPkg::wordT    dmem [`MIPS_DMEM_DEPTH];
	logic [dmemAw-1:0] dmemIdx;
	mipsPkg::wordT    loadData;
	logic             memwbRegWrite;
	logic             memwbMemtoReg;
	mipsPkg::regAddrT memwbDst;
	mipsPkg::wordT    memwbAlu;
	mipsPkg::wordT    memwbLoad;

	// ALU gives a byte address, drop the low two bits for the word index
	assign dmemIdx = exmemAlu[dmemAw+1:2];

	// combinational read, only for loads
	assign loadData = exmemCtrl.memRead ? dmem[dmemIdx] : '0;

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `MIPS_DMEM_DEPTH; i++) begin
				dmem[i] <= '0;
			end
		end else if (exmemCtrl.memWrite) begin
			dmem[dmemIdx] <= exmemStore;
		end
	end

	// memory/write-back register
	always_ff @(posedge clk) begin
		if (reset) begin
			memwbRegWrite <= 1'b0;
			memwbMemtoReg <= 1'b0;
		end else begin
			memwbRegWrite <= exmemCtrl.regWrite;
			memwbMemtoReg <= exmemCtrl.memtoReg;
		end
	end

	always_ff @(posedge clk) begin
		memwbDst <= exmemDst;
		memwbAlu <= exmemAlu;
		memwbLoad <= loadData;
	end

	// writes to r0 are dropped here, so nothing downstream sees them
	assign wbValid = memwbRegWrite && (memwbDst != '0);
	assign wbReg = memwbDst;
	assign wbData = memwbMemtoReg ? memwbLoad : memwbAlu;

	// main control never asks for a read and a write together
	assert property (@(posedge clk) disable iff (reset)
		!(exmemCtrl.memRead && exmemCtrl.memWrite))
		else $error("data memory read and write in one cycle");

endmodule

/* verilog/executeStage.sv */
// operand forwarding, ALU control, ALU, destination select, execute/memory register
`timescale 1ns/100ps
`include "mips_settings.svh"

module executeStage (
	input  logic             clk,
	input  logic             reset,
	input  mipsPkg::ctrlT    idexCtrl,
	input  mipsPkg::regAddrT idexRt,
	input  mipsPkg::regAddrT idexRd,
	input  mipsPkg::wordT    idexA,
	input  mipsPkg::wordT    idexB,
	input  mipsPkg::wordT    idexImm,
	input  logic [1:0]       fwdA,
	input  logic [1:0]       fwdB,
	input  mipsPkg::wordT    wbData,
	output mipsPkg::ctrlT    exmemCtrl,
	output mipsPkg::wordT    exmemAlu,
	output mipsPkg::wordT    exmemStore,
	output mipsPkg::regAddrT exmemDst
);

	mipsPkg::wordT    opA;
	mipsPkg::wordT    opB;
	mipsPkg::wordT    storeData;
	mipsPkg::wordT    aluOut;
	mipsPkg::aluOpT   aluOp;
	mipsPkg::regAddrT dst;

	// forwarding mux, the execute/memory result is this stage's own register
	function automatic mipsPkg::wordT fwdMux(
		input logic [1:0]    sel,
		input mipsPkg::wordT regVal
	);
		case (sel)
			2'b10: return exmemAlu;
			2'b01: return wbData;
			default: return regVal;
		endcase
	endfunction

	always_comb begin
		opA = fwdMux(fwdA, idexA);
		// forwarded rt also feeds the store data
		storeData = fwdMux(fwdB, idexB);
		opB = idexCtrl.aluSrc ? idexImm : storeData;
	end

	// ALU control, function field sits in the low bits of the immediate
	always_comb begin
		aluOp = mipsPkg::aluAdd;
		if (idexCtrl.aluMode == mipsPkg::modeFunct) begin
			case (idexImm[5:0])
				`MIPS_FN_ADD: aluOp = mipsPkg::aluAdd;
				`MIPS_FN_SUB: aluOp = mipsPkg::aluSub;
				`MIPS_FN_AND: aluOp = mipsPkg::aluAnd;
				`MIPS_FN_OR: aluOp = mipsPkg::aluOr;
				`MIPS_FN_SLT: aluOp = mipsPkg::aluSlt;
				default: aluOp = mipsPkg::aluAdd;
			endcase
		end
	end

	// ALU, slt compares signed
	always_comb begin
		case (aluOp)
			mipsPkg::aluSub: aluOut = opA - opB;
			mipsPkg::aluAnd: aluOut = opA & opB;
			mipsPkg::aluOr: aluOut = opA | opB;
			mipsPkg::aluSlt: aluOut = {{(`MIPS_WORD_W - 1){1'b0}}, $signed(opA) < $signed(opB)};
			default: aluOut = opA + opB;
		endcase
	end

	// rd for R-type, rt otherwise
	assign dst = idexCtrl.regDst ? idexRd : idexRt;

	always_ff @(posedge clk) begin
		if (reset) begin
			exmemCtrl <= '0;
		end else begin
			exmemCtrl <= idexCtrl;
		end
	end

	always_ff @(posedge clk) begin
		exmemAlu <= aluOut;
		exmemStore <= storeData;
		exmemDst <= dst;
	end

endmodule

/* verilog/forwardUnit.sv */
// forwarding source select for the two ALU operands
`timescale 1ns/100ps

module forwardUnit (
	input  mipsPkg::regAddrT idexRs,
	input  mipsPkg::regAddrT idexRt,
	input  mipsPkg::ctrlT    exmemCtrl,
	input  mipsPkg::regAddrT exmemDst,
	input  logic             wbValid,
	input  mipsPkg::regAddrT wbReg,
	output logic [1:0]       fwdA,
	output logic [1:0]       fwdB
);

	logic exmemWrites;

	// a result in execute/memory only counts when it lands in a real register
	assign exmemWrites = exmemCtrl.regWrite && (exmemDst != '0);

	// 2'b10 execute/memory, 2'b01 write-back, 2'b00 register file
	// the nearer stage is checked first so it wins
	function automatic logic [1:0] pickSource(input mipsPkg::regAddrT src);
		if (exmemWrites && (exmemDst == src)) begin
			return 2'b10;
		end
		if (wbValid && (wbReg == src)) begin
			return 2'b01;
		end
		return 2'b00;
	endfunction

	always_comb begin
		fwdA = pickSource(idexRs);
		fwdB = pickSource(idexRt);
	end

endmodule

/* verilog/decodeStage.sv */
// main control, register file, sign extension and the decode/execute register
`timescale 1ns/100ps
`include "mips_settings.svh"

module decodeStage (
	input  logic             clk,
	input  logic             reset,
	input  mipsPkg::instrT   ifidInstr,
	input  logic             wbValid,
	input  mipsPkg::regAddrT wbReg,
	input  mipsPkg::wordT    wbData,
	output mipsPkg::ctrlT    idexCtrl,
	output mipsPkg::regAddrT idexRs,
	output mipsPkg::regAddrT idexRt,
	output mipsPkg::regAddrT idexRd,
	output mipsPkg::wordT    idexA,
	output mipsPkg::wordT    idexB,
	output mipsPkg::wordT    idexImm
);

	localparam int regCount = 1 << `MIPS_REG_ADDR_W;

	mipsPkg::regAddrT rs;
	mipsPkg::regAddrT rt;
	mipsPkg::regAddrT rd;
	mipsPkg::ctrlT    ctrl;
	mipsPkg::wordT    readA;
	mipsPkg::wordT    readB;
	mipsPkg::wordT    imm;
	mipsPkg::wordT    regs [regCount];

	// instruction fields
	assign rs = ifidInstr[25:21];
	assign rt = ifidInstr[20:16];
	assign rd = ifidInstr[15:11];

	// 16 bit immediate sign extended to a word
	assign imm = {{(`MIPS_WORD_W - 16){ifidInstr[15]}}, ifidInstr[15:0]};

	// main control turns anything unknown into a bubble
	always_comb begin
		ctrl = '0;
		case (ifidInstr[31:26])
			`MIPS_OP_RTYPE: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst = 1'b1;
				ctrl.aluMode = mipsPkg::modeFunct;
			end
			`MIPS_OP_LW: begin
				ctrl.regWrite = 1'b1;
				ctrl.memtoReg = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.aluMode = mipsPkg::modeMem;
			end
			`MIPS_OP_SW: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.aluMode = mipsPkg::modeMem;
			end
			`MIPS_OP_ADDI: begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.aluMode = mipsPkg::modeImm;
			end
			default: begin
				ctrl = '0;
			end
		endcase
	end

	// register file written from the write-back stream
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (wbValid) begin
			regs[wbReg] <= wbData;
		end
	end

	// read port gives zero for r0 and passes a same-cycle write straight through
	function automatic mipsPkg::wordT readReg(input mipsPkg::regAddrT addr);
		if (addr == '0) begin
			return '0;
		end
		if (wbValid && (wbReg == addr)) begin
			return wbData;
		end
		return regs[addr];
	endfunction

	always_comb begin
		readA = readReg(rs);
		readB = readReg(rt);
	end

	// decode/execute register, a bubble enters on reset
	always_ff @(posedge clk) begin
		if (reset) begin
			idexCtrl <= '0;
		end else begin
			idexCtrl <= ctrl;
		end
	end

	// register numbers and operands for execute
	always_ff @(posedge clk) begin
		idexRs <= rs;
		idexRt <= rt;
		idexRd <= rd;
		idexA <= readA;
		idexB <= readB;
		idexImm <= imm;
	end

	// write-back from the memory stage never targets r0
	assert property (@(posedge clk) disable iff (reset) wbValid |-> (wbReg != '0))
		else $error("write-back to r0");

endmodule

/* verilog/fetchStage.sv */
// program counter, instruction memory with load port, fetch/decode register
`timescale 1ns/100ps
`include "mips_settings.svh"

module fetchStage (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               progWrite,
	input  logic [$clog2(`MIPS_IMEM_DEPTH)-1:0] progAddr,
	input  mipsPkg::instrT                     progData,
	output mipsPkg::instrT                     ifidInstr
);

	localparam int imemAw = $clog2(`MIPS_IMEM_DEPTH);

	// pc counts words, no branches so it only steps by one
	logic [imemAw-1:0] pc;
	mipsPkg::instrT imem [`MIPS_IMEM_DEPTH];

	// program image comes in through the load port
	always_ff @(posedge clk) begin
		if (progWrite) begin
			imem[progAddr] <= progData;
		end
	end

	// pc sits at 0 during reset, so word 0 is fetched in the first cycle after
	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
			ifidInstr <= '0;
		end else begin
			pc <= pc + 1'b1;
			ifidInstr <= imem[pc];
		end
	end

	// loading is only allowed while the pipeline is held in reset
	assert property (@(posedge clk) !reset |-> !progWrite)
		else $error("program write while running");

endmodule

/* verilog/mipsPkg.sv */
// datapath types shared by the MIPS pipeline stages
`include "mips_settings.svh"

package mipsPkg;

	// data word and instruction word
	typedef logic [`MIPS_WORD_W-1:0] wordT;
	typedef logic [`MIPS_WORD_W-1:0] instrT;

	// register number, r0 is hardwired to zero
	typedef logic [`MIPS_REG_ADDR_W-1:0] regAddrT;

	// operation carried out by the ALU
	typedef enum logic [2:0] {
		aluAdd = 3'd0,
		aluSub = 3'd1,
		aluAnd = 3'd2,
		aluOr  = 3'd3,
		aluSlt = 3'd4
	} aluOpT;

	// class of ALU work picked by main control
	// mem and imm both add, funct defers to the function field
	typedef enum logic [1:0] {
		modeMem   = 2'd0,
		modeImm   = 2'd1,
		modeFunct = 2'd2
	} aluModeT;

	// control bundle carried down the pipe, all zero is a bubble
	typedef struct packed {
		logic    regWrite;
		logic    memtoReg;
		logic    memRead;
		logic    memWrite;
		logic    aluSrc;
		logic    regDst;
		aluModeT aluMode;
	} ctrlT;

endpackage

/* verilog/mips_settings.svh */
// widths, memory depths and instruction encodings of the MIPS core
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// datapath and register-number widths
`define MIPS_WORD_W     32
`define MIPS_REG_ADDR_W 5

// memory sizes in words
`define MIPS_IMEM_DEPTH 64
`define MIPS_DMEM_DEPTH 64

// opcodes, instruction bits 31:26
`define MIPS_OP_RTYPE 6'd0
`define MIPS_OP_LW    6'd35
`define MIPS_OP_SW    6'd43
`define MIPS_OP_ADDI  6'd8

// R-type function codes, instruction bits 5:0
`define MIPS_FN_ADD 6'd32
`define MIPS_FN_SUB 6'd34
`define MIPS_FN_AND 6'd36
`define MIPS_FN_OR  6'd37
`define MIPS_FN_SLT 6'd42

`endif
